// ==== hdl/dcache_pkg.sv ====
// shared geometry and encodings for the data cache
// 2-way set-associative, one 64-bit word per line, 64 sets
// address split is tag 23 / index 6 / offset 3, physical address only
// response codes follow the AXI 2-bit encoding, only OKAY is named
package dcache_pkg;

  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 64;
  localparam int STRB_W   = 8;   // one strobe per byte
  localparam int TAG_W    = 23;
  localparam int INDEX_W  = 6;
  localparam int OFFSET_W = 3;
  localparam int NUM_WAYS = 2;
  localparam int NUM_SETS = 64;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cache_op_e;

  // miss path goes wb_* (dirty victim only), then fill_*, then back to lookup
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_RESP,
    ST_WB_AW,
    ST_WB_W,
    ST_WB_B,
    ST_FILL_AR,
    ST_FILL_R
  } ctrl_state_e;

endpackage

// ==== hdl/cache_array_if.sv ====
// array bundle between the cache controller and the tag/data arrays
// lookup_tag is the tag of the registered request address, used for compare and fill
// way selects the way for data and tag writes, 1 bit for 2 ways
`timescale 1ns/1ps

interface cache_array_if
  import dcache_pkg::*;
();

  logic [INDEX_W-1:0]                index;
  logic [TAG_W-1:0]                  lookup_tag;
  logic                              way;
  logic                              data_we;
  logic [STRB_W-1:0]                 data_wstrb;
  logic [DATA_W-1:0]                 data_wdata;
  logic                              rd_en;
  logic                              tag_we;
  logic                              tag_valid;
  logic                              tag_dirty;
  logic                              alloc;     // advance victim pointer of index
  logic [NUM_WAYS-1:0][DATA_W-1:0]   rdata;     // both ways, one cycle after rd_en
  logic                              hit;
  logic                              hit_way;
  logic                              victim_way;
  logic                              victim_dirty;
  logic [TAG_W-1:0]                  victim_tag;

  modport ctrl (
    output index, lookup_tag, way, data_we, data_wstrb, data_wdata, rd_en,
    output tag_we, tag_valid, tag_dirty, alloc,
    input  rdata, hit, hit_way, victim_way, victim_dirty, victim_tag
  );

  modport tag (
    input  index, lookup_tag, way, tag_we, tag_valid, tag_dirty, alloc,
    output hit, hit_way, victim_way, victim_dirty, victim_tag
  );

  modport data (
    input  index, way, data_we, data_wstrb, data_wdata, rd_en,
    output rdata
  );

endinterface

// ==== hdl/dcache_tag_array.sv ====
// tag, valid and dirty storage for both ways, plus round-robin victim bit per set
// lookup is combinational on index/tag, writes land at the next edge
// victim pointer toggles on alloc, so it only suits 2 ways
// dirty is reported only for a valid victim
`timescale 1ns/1ps

module dcache_tag_array
  import dcache_pkg::*;
(
  input logic        clk,
  input logic        rst,
  cache_array_if.tag arr
);

  logic [TAG_W-1:0]    tag_mem [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
  logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];
  logic [NUM_SETS-1:0] victim_q;
  logic [NUM_WAYS-1:0] way_hit;
  logic                hit_way;
  logic                victim;

  always_comb begin
    hit_way = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = valid_q[w][arr.index] && (tag_mem[w][arr.index] == arr.lookup_tag);
      if (way_hit[w]) begin
        hit_way = w[0];
      end
    end
  end

  assign victim           = victim_q[arr.index];
  assign arr.hit          = |way_hit;
  assign arr.hit_way      = hit_way;
  assign arr.victim_way   = victim;
  assign arr.victim_dirty = valid_q[victim][arr.index] && dirty_q[victim][arr.index];
  assign arr.victim_tag   = tag_mem[victim][arr.index];   // for write-back address

  always_ff @(posedge clk) begin
    if (arr.tag_we) begin
      tag_mem[arr.way][arr.index] <= arr.lookup_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
      victim_q <= '0;
    end else begin
      if (arr.tag_we) begin
        valid_q[arr.way][arr.index] <= arr.tag_valid;
        dirty_q[arr.way][arr.index] <= arr.tag_dirty;
      end
      if (arr.alloc) begin
        victim_q[arr.index] <= ~victim_q[arr.index];  // round robin
      end
    end
  end

  // the controller must never fill a tag that is already present in the set
  a_single_hit: assert property (@(posedge clk) disable iff (rst)
    $onehot0(way_hit))
    else $error("tag array: more than one way hits");

endmodule

// ==== hdl/dcache_data_array.sv ====
// two-way data storage, one 64-bit word per set and way
// byte-strobed writes, synchronous read of both ways
// read data holds until the next rd_en, no read-during-write bypass
`timescale 1ns/1ps

module dcache_data_array
  import dcache_pkg::*;
(
  input logic         clk,
  cache_array_if.data arr
);

  logic [DATA_W-1:0]               mem [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0][DATA_W-1:0] rdata_q;

  // strobed write into the selected way
  always_ff @(posedge clk) begin
    if (arr.data_we) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (arr.data_wstrb[b]) begin
          mem[arr.way][arr.index][b*8 +: 8] <= arr.data_wdata[b*8 +: 8];
        end
      end
    end
  end

  // both ways read, way select happens in the controller
  always_ff @(posedge clk) begin
    if (arr.rd_en) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        rdata_q[w] <= mem[w][arr.index];
      end
    end
  end

  assign arr.rdata = rdata_q;

endmodule

// ==== hdl/dcache_ctrl.sv ====
// request FSM of the data cache, one CPU request in flight
// misses write back a dirty victim (aw, w, b), refill over ar/r, then redo
// the lookup so the request finishes as a hit
// non-OKAY r/b codes are passed back on resp_code_o, the line is still filled
// memory channels are single beat, word aligned, w always full strobe
`timescale 1ns/1ps

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  cache_op_e         req_op_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  input  logic [STRB_W-1:0] req_wstrb_i,
  output logic              resp_valid_o,
  input  logic              resp_ready_i,
  output logic [DATA_W-1:0] resp_rdata_o,
  output logic [1:0]        resp_code_o,
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output logic [ADDR_W-1:0] mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  output logic              mem_r_ready_o,
  input  logic [DATA_W-1:0] mem_r_data_i,
  input  logic [1:0]        mem_r_resp_i,
  output logic              mem_aw_valid_o,
  input  logic              mem_aw_ready_i,
  output logic [ADDR_W-1:0] mem_aw_addr_o,
  output logic              mem_w_valid_o,
  input  logic              mem_w_ready_i,
  output logic [DATA_W-1:0] mem_w_data_o,
  input  logic              mem_b_valid_i,
  output logic              mem_b_ready_o,
  input  logic [1:0]        mem_b_resp_i,
  cache_array_if.ctrl       arr
);

  ctrl_state_e       state_q, state_d;
  cache_op_e         op_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] wstrb_q;
  logic              way_q;        // hit way, or victim way on a miss
  logic [ADDR_W-1:0] wb_addr_q;
  logic [1:0]        code_q;
  logic              req_fire;
  logic              wr_hit;
  logic              r_done;
  logic              b_done;

  assign req_fire = req_valid_i && req_ready_o;
  assign wr_hit   = (state_q == ST_LOOKUP) && arr.hit && (op_q == OP_WRITE);
  assign r_done   = mem_r_valid_i && mem_r_ready_o;
  assign b_done   = mem_b_valid_i && mem_b_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:    if (req_valid_i) state_d = ST_LOOKUP;
      ST_LOOKUP: begin
        if (arr.hit) state_d = ST_RESP;
        else if (arr.victim_dirty) state_d = ST_WB_AW;
        else state_d = ST_FILL_AR;
      end
      ST_RESP:    if (resp_ready_i) state_d = ST_IDLE;
      ST_WB_AW:   if (mem_aw_ready_i) state_d = ST_WB_W;
      ST_WB_W:    if (mem_w_ready_i) state_d = ST_WB_B;
      ST_WB_B:    if (mem_b_valid_i) state_d = ST_FILL_AR;
      ST_FILL_AR: if (mem_ar_ready_i) state_d = ST_FILL_R;
      ST_FILL_R:  if (mem_r_valid_i) state_d = ST_LOOKUP;
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      code_q  <= RESP_OKAY;
    end else begin
      state_q <= state_d;
      if (req_fire) begin
        code_q <= RESP_OKAY;
      end else if (r_done && mem_r_resp_i != RESP_OKAY) begin
        code_q <= mem_r_resp_i;
      end else if (b_done && mem_b_resp_i != RESP_OKAY) begin
        code_q <= mem_b_resp_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      op_q    <= req_op_i;
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
      wstrb_q <= req_wstrb_i;
    end
    if (state_q == ST_LOOKUP) begin
      way_q     <= arr.hit ? arr.hit_way : arr.victim_way;
      wb_addr_q <= {arr.victim_tag, arr.index, {OFFSET_W{1'b0}}};
    end
  end

  // array controls, fill writes the whole word as clean, store hit merges and dirties
  assign arr.index      = addr_q[OFFSET_W +: INDEX_W];
  assign arr.lookup_tag = addr_q[ADDR_W-1 -: TAG_W];
  assign arr.way        = (state_q == ST_LOOKUP) ? arr.hit_way : way_q;
  assign arr.rd_en      = (state_q == ST_LOOKUP);
  assign arr.data_we    = wr_hit || r_done;
  assign arr.data_wstrb = wr_hit ? wstrb_q : '1;
  assign arr.data_wdata = wr_hit ? wdata_q : mem_r_data_i;
  assign arr.tag_we     = wr_hit || r_done;
  assign arr.tag_valid  = 1'b1;
  assign arr.tag_dirty  = wr_hit;
  assign arr.alloc      = r_done;

  assign req_ready_o  = (state_q == ST_IDLE);
  assign resp_valid_o = (state_q == ST_RESP);
  assign resp_rdata_o = (op_q == OP_READ) ? arr.rdata[way_q] : '0;
  assign resp_code_o  = code_q;

  assign mem_aw_valid_o = (state_q == ST_WB_AW);
  assign mem_aw_addr_o  = wb_addr_q;
  assign mem_w_valid_o  = (state_q == ST_WB_W);
  assign mem_w_data_o   = arr.rdata[way_q];   // victim word, read during lookup
  assign mem_b_ready_o  = (state_q == ST_WB_B);
  assign mem_ar_valid_o = (state_q == ST_FILL_AR);
  assign mem_ar_addr_o  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign mem_r_ready_o  = (state_q == ST_FILL_R);

  // memory valids hold with stable payload until accepted
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o));
  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    mem_aw_valid_o && !mem_aw_ready_i |=> mem_aw_valid_o && $stable(mem_aw_addr_o));
  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    mem_w_valid_o && !mem_w_ready_i |=> mem_w_valid_o && $stable(mem_w_data_o));

endmodule

// ==== hdl/dcache_top.sv ====
// data cache top, CPU load/store port on one side, single-beat AXI-style
// memory port on the other
// no latency added here, all timing comes from the controller
`timescale 1ns/1ps

module dcache_top
  import dcache_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  cache_op_e         req_op_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  input  logic [STRB_W-1:0] req_wstrb_i,
  output logic              resp_valid_o,
  input  logic              resp_ready_i,
  output logic [DATA_W-1:0] resp_rdata_o,
  output logic [1:0]        resp_code_o,
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output logic [ADDR_W-1:0] mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  output logic              mem_r_ready_o,
  input  logic [DATA_W-1:0] mem_r_data_i,
  input  logic [1:0]        mem_r_resp_i,
  output logic              mem_aw_valid_o,
  input  logic              mem_aw_ready_i,
  output logic [ADDR_W-1:0] mem_aw_addr_o,
  output logic              mem_w_valid_o,
  input  logic              mem_w_ready_i,
  output logic [DATA_W-1:0] mem_w_data_o,
  input  logic              mem_b_valid_i,
  output logic              mem_b_ready_o,
  input  logic [1:0]        mem_b_resp_i
);

  cache_array_if arr_if ();

  // port names match one to one
  dcache_ctrl dcache_ctrl_inst (
    .*,
    .arr (arr_if.ctrl)
  );

  dcache_tag_array dcache_tag_array_inst (
    .clk (clk),
    .rst (rst),
    .arr (arr_if.tag)
  );

  dcache_data_array dcache_data_array_inst (
    .clk (clk),
    .arr (arr_if.data)
  );

endmodule

// ==== verification/dcache_checker.sv ====
// watches the cache ports and compares against a shadow of memory
// ports carry the DUT signal names, connected by name from the testbench
// shadow covers the 8 KB window at address zero, same init as the memory model
`timescale 1ns/1ps

module dcache_checker
  import dcache_pkg::*;
(
  input  logic              clk, rst,
  input  logic              req_valid_i, req_ready_o,
  input  cache_op_e         req_op_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  input  logic [STRB_W-1:0] req_wstrb_i,
  input  logic              resp_valid_o, resp_ready_i,
  input  logic [DATA_W-1:0] resp_rdata_o,
  input  logic [1:0]        resp_code_o,
  input  logic              mem_ar_valid_o, mem_ar_ready_i, mem_r_ready_o, mem_b_ready_o,
  input  logic [ADDR_W-1:0] mem_ar_addr_o,
  input  logic              mem_aw_valid_o, mem_aw_ready_i,
  input  logic [ADDR_W-1:0] mem_aw_addr_o,
  input  logic              mem_w_valid_o, mem_w_ready_i,
  input  logic [DATA_W-1:0] mem_w_data_o,
  input  logic              hit_chk_i,
  input  logic [1:0]        exp_code_i,
  output int                err_count_o,
  output int                test_count_o
);

  logic [DATA_W-1:0]   shadow [1024];
  logic [NUM_SETS-1:0] set_written;   // sets that ever saw a store
  logic [ADDR_W-1:0]   addr_q, aw_addr_q, exp_addr;
  cache_op_e           op_q;
  logic [1:0]          code_q, code_prev;
  logic [DATA_W-1:0]   rdata_prev, exp_word;
  logic                chk_q, busy, seen, started, stall_q, bad;
  int                  lat;

  function automatic logic [DATA_W-1:0] init_word(logic [ADDR_W-1:0] a);
    return {a ^ 32'h9e37_79b9, ~a + 32'h6c07_8965};
  endfunction

  task automatic log_error(input string msg);
    $display("%s", msg);
    err_count_o++;
    bad = 1'b1;
  endtask

  initial begin
    for (int k = 0; k < 1024; k++) begin
      shadow[k] = init_word(k * 8);
    end
    set_written  = '0;
    err_count_o  = 0;
    test_count_o = 0;
    {busy, seen, started, stall_q, bad} = '0;
  end

  always @(posedge clk) begin
    if (!rst && !started) begin
      if (req_valid_i) begin
        started = 1'b1;
      end else if (!req_ready_o || mem_ar_valid_o || mem_aw_valid_o || mem_w_valid_o ||
                   mem_r_ready_o || mem_b_ready_o) begin
        log_error($sformatf("at %0t after reset the cache is not idle", $time));
      end
    end
    if (stall_q && (!resp_valid_o || resp_rdata_o != rdata_prev || resp_code_o != code_prev))
      log_error($sformatf("at %0t response changed while resp_ready_i was low", $time));
    stall_q    = resp_valid_o && !resp_ready_i;
    rdata_prev = resp_rdata_o;
    code_prev  = resp_code_o;
    if (busy && !seen) begin
      lat++;
      if (resp_valid_o) begin
        seen = 1'b1;
        if (chk_q && lat != 2)
          log_error($sformatf("at %0t hit answered %0d cycles after acceptance", $time, lat));
      end
    end
    if (busy && resp_valid_o && resp_ready_i) begin
      exp_word = (op_q == OP_READ) ? shadow[addr_q[12:3]] : '0;   // writes answer zero
      if (resp_rdata_o != exp_word)
        log_error($sformatf("Mismatch at %0t: addr %h data %h, expected %h",
                            $time, addr_q, resp_rdata_o, exp_word));
      if (resp_code_o != code_q)
        log_error($sformatf("Mismatch at %0t: addr %h code %0d, expected %0d",
                            $time, addr_q, resp_code_o, code_q));
      $display("test %0d %s %h: %s", test_count_o, (op_q == OP_READ) ? "read " : "write",
               addr_q, bad ? "FAIL" : "ok");
      test_count_o++;
      busy = 1'b0;
    end
    if (req_valid_i && req_ready_o) begin
      {busy, seen, bad} = 3'b100;
      lat    = 0;
      op_q   = req_op_i;
      addr_q = req_addr_i;
      chk_q  = hit_chk_i;
      code_q = exp_code_i;
      if (req_op_i == OP_WRITE) begin
        set_written[req_addr_i[OFFSET_W +: INDEX_W]] = 1'b1;
        for (int b = 0; b < STRB_W; b++) begin
          if (req_wstrb_i[b]) shadow[req_addr_i[12:3]][b*8 +: 8] = req_wdata_i[b*8 +: 8];
        end
      end
    end
    if (mem_ar_valid_o && mem_ar_ready_i) begin
      exp_addr = addr_q & ~32'h7;   // refill of the requested word
      if (mem_ar_addr_o != exp_addr)
        log_error($sformatf("Mismatch at %0t: fill address %h, expected %h",
                            $time, mem_ar_addr_o, exp_addr));
    end
    if (mem_aw_valid_o && mem_aw_ready_i) begin
      aw_addr_q = mem_aw_addr_o;
      if (!set_written[mem_aw_addr_o[OFFSET_W +: INDEX_W]])
        log_error($sformatf("at %0t write-back of %h from a set that was only read",
                            $time, mem_aw_addr_o));
      if (mem_aw_addr_o[2:0] != 3'b000 ||
          mem_aw_addr_o[OFFSET_W +: INDEX_W] != addr_q[OFFSET_W +: INDEX_W])
        log_error($sformatf("Mismatch at %0t: write-back address %h for request %h",
                            $time, mem_aw_addr_o, addr_q));
    end
    if (mem_w_valid_o && mem_w_ready_i && mem_w_data_o != shadow[aw_addr_q[12:3]])
      log_error($sformatf("Mismatch at %0t: write-back to %h data %h, expected %h",
                          $time, aw_addr_q, mem_w_data_o, shadow[aw_addr_q[12:3]]));
  end

endmodule

// ==== verification/dcache_tb.sv ====
// testbench for the data cache, table driven, one request in flight
// memory model covers an 8 KB window at address zero, table addresses stay inside it
// memory ready/valid delays and resp_ready_i come from an LCG with a fixed seed
`timescale 1ns/1ps

module dcache_tb
  import dcache_pkg::*;
();

  localparam int NUM_TESTS  = 24;
  localparam int MAX_CYCLES = NUM_TESTS * 60 + 100;

  typedef struct packed {
    cache_op_e         op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    logic [1:0]        code;   // injected on r/b, expected on resp
  } entry_t;

  logic              clk, rst;
  logic              req_valid_i, req_ready_o, resp_valid_o, resp_ready_i;
  cache_op_e         req_op_i;
  logic [ADDR_W-1:0] req_addr_i, mem_ar_addr_o, mem_aw_addr_o;
  logic [DATA_W-1:0] req_wdata_i, resp_rdata_o, mem_r_data_i, mem_w_data_o;
  logic [STRB_W-1:0] req_wstrb_i;
  logic [1:0]        resp_code_o, mem_r_resp_i, mem_b_resp_i;
  logic              mem_ar_valid_o, mem_ar_ready_i, mem_r_valid_i, mem_r_ready_o;
  logic              mem_aw_valid_o, mem_aw_ready_i, mem_w_valid_o, mem_w_ready_i;
  logic              mem_b_valid_i, mem_b_ready_o;
  logic              hit_chk_i;    // request repeats the previous address
  logic [1:0]        exp_code_i;
  int                err_count_o, test_count_o;

  entry_t            tbl [NUM_TESTS];
  logic [DATA_W-1:0] mem [1024];
  logic [31:0]       seed;
  logic [ADDR_W-1:0] rd_addr, wr_addr, prev_addr;
  logic              r_pend, b_pend;

  dcache_top dcache_top_inst (.*);
  dcache_checker watcher (.*);

  function automatic logic [DATA_W-1:0] init_word(logic [ADDR_W-1:0] a);
    return {a ^ 32'h9e37_79b9, ~a + 32'h6c07_8965};
  endfunction

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("timeout: no result after %0d cycles, the cache stopped responding", MAX_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  // memory model
  initial begin
    for (int k = 0; k < 1024; k++) begin
      mem[k] = init_word(k * 8);
    end
    {mem_ar_ready_i, mem_r_valid_i, mem_aw_ready_i, mem_w_ready_i, mem_b_valid_i} = '0;
    {mem_r_data_i, mem_r_resp_i, mem_b_resp_i, resp_ready_i, r_pend, b_pend} = '0;
    seed = 32'h40e5_ef62;
    forever begin
      @(posedge clk);
      seed = lcg_next(seed);
      resp_ready_i   <= hit_chk_i || (seed[26:25] != 2'b00);
      mem_ar_ready_i <= seed[31];
      mem_aw_ready_i <= seed[30];
      mem_w_ready_i  <= seed[29];
      if (mem_ar_valid_o && mem_ar_ready_i) begin
        r_pend  <= 1'b1;
        rd_addr <= mem_ar_addr_o;
      end
      if (mem_r_valid_i && mem_r_ready_o) begin
        mem_r_valid_i <= 1'b0;
      end else if (r_pend && !mem_r_valid_i && seed[28]) begin
        mem_r_valid_i <= 1'b1;
        mem_r_data_i  <= mem[rd_addr[12:3]];
        mem_r_resp_i  <= exp_code_i;
        r_pend        <= 1'b0;
      end
      if (mem_aw_valid_o && mem_aw_ready_i) wr_addr <= mem_aw_addr_o;
      if (mem_w_valid_o && mem_w_ready_i) begin
        mem[wr_addr[12:3]] <= mem_w_data_o;   // w is always full strobe
        b_pend             <= 1'b1;
      end
      if (mem_b_valid_i && mem_b_ready_o) begin
        mem_b_valid_i <= 1'b0;
      end else if (b_pend && !mem_b_valid_i && seed[27]) begin
        mem_b_valid_i <= 1'b1;
        mem_b_resp_i  <= exp_code_i;
        b_pend        <= 1'b0;
      end
    end
  end

  initial begin
    rst         = 1'b1;
    req_valid_i = 1'b0;
    req_op_i    = OP_READ;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_wstrb_i = '0;
    hit_chk_i   = 1'b0;
    exp_code_i  = RESP_OKAY;
    prev_addr   = '1;
    // op, address, write data, strobe, memory code
    tbl[0]  = {OP_READ,  32'h0000_0008, 64'h0, 8'h00, 2'b00};  // cold miss, then hit
    tbl[1]  = {OP_READ,  32'h0000_0008, 64'h0, 8'h00, 2'b00};
    tbl[2]  = {OP_READ,  32'h0000_0010, 64'h0, 8'h00, 2'b00};
    tbl[3]  = {OP_READ,  32'h0000_0010, 64'h0, 8'h00, 2'b00};
    tbl[4]  = {OP_WRITE, 32'h0000_0010, 64'h1111_2222_3333_4444, 8'h0f, 2'b00};  // write hit
    tbl[5]  = {OP_READ,  32'h0000_0010, 64'h0, 8'h00, 2'b00};
    tbl[6]  = {OP_WRITE, 32'h0000_0100, 64'haabb_ccdd_eeff_0011, 8'hf0, 2'b00};  // write miss
    tbl[7]  = {OP_READ,  32'h0000_0100, 64'h0, 8'h00, 2'b00};
    tbl[8]  = {OP_WRITE, 32'h0000_0028, 64'h0123_4567_89ab_cdef, 8'hff, 2'b00};  // set 5
    tbl[9]  = {OP_WRITE, 32'h0000_0228, 64'hfedc_ba98_7654_3210, 8'h3c, 2'b00};
    tbl[10] = {OP_WRITE, 32'h0000_0428, 64'h5555_aaaa_5555_aaaa, 8'hff, 2'b00};
    tbl[11] = {OP_READ,  32'h0000_0028, 64'h0, 8'h00, 2'b00};
    tbl[12] = {OP_READ,  32'h0000_0228, 64'h0, 8'h00, 2'b00};
    tbl[13] = {OP_READ,  32'h0000_0428, 64'h0, 8'h00, 2'b00};
    tbl[14] = {OP_READ,  32'h0000_0018, 64'h0, 8'h00, 2'b00};  // set 3, read only
    tbl[15] = {OP_READ,  32'h0000_0218, 64'h0, 8'h00, 2'b00};
    tbl[16] = {OP_READ,  32'h0000_0418, 64'h0, 8'h00, 2'b00};
    tbl[17] = {OP_READ,  32'h0000_0018, 64'h0, 8'h00, 2'b00};
    tbl[18] = {OP_READ,  32'h0000_0030, 64'h0, 8'h00, 2'b10};  // slave error on r
    tbl[19] = {OP_READ,  32'h0000_0030, 64'h0, 8'h00, 2'b00};
    tbl[20] = {OP_WRITE, 32'h0000_0038, 64'h7777_8888_9999_0000, 8'hc3, 2'b11};
    tbl[21] = {OP_READ,  32'h0000_0038, 64'h0, 8'h00, 2'b00};
    tbl[22] = {OP_WRITE, 32'h0000_1ff8, 64'h1234_0000_0000_5678, 8'h81, 2'b00};
    tbl[23] = {OP_READ,  32'h0000_1ff8, 64'h0, 8'h00, 2'b00};
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (3) @(posedge clk);   // idle cycles for the reset state check
    for (int i = 0; i < NUM_TESTS; i++) begin
      req_valid_i <= 1'b1;
      req_op_i    <= tbl[i].op;
      req_addr_i  <= tbl[i].addr;
      req_wdata_i <= tbl[i].wdata;
      req_wstrb_i <= tbl[i].strb;
      exp_code_i  <= tbl[i].code;
      hit_chk_i   <= (tbl[i].addr == prev_addr);
      prev_addr   = tbl[i].addr;
      do @(posedge clk); while (!req_ready_o);
      req_valid_i <= 1'b0;
      do @(posedge clk); while (!(resp_valid_o && resp_ready_i));
    end
    repeat (2) @(posedge clk);
    $display("tests run %0d of %0d, errors %0d", test_count_o, NUM_TESTS, err_count_o);
    if (err_count_o == 0 && test_count_o == NUM_TESTS) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== dcache_sub.f ====
hdl/dcache_pkg.sv
hdl/cache_array_if.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_tb.sv
